// ==== rtl/corr_pkg.sv ====
// accumulation mode enum, readout state enum and baseline count function
package corr_pkg;

	// how a fresh sample of the leading input of a baseline is counted
	typedef enum logic {
		mode_cumulative = 1'b0, // every fresh sample counts
		mode_transition = 1'b1  // only a sample that differs from the previous one
	} accum_mode_e;

	// readout sequencer
	typedef enum logic {
		rd_idle = 1'b0,
		rd_send = 1'b1
	} readout_state_e;

	// number of baselines (pairs i<j) for n inputs
	//
	// baseline index b walks the pairs with i outer and j inner
	// four inputs give (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
	// b = i*n - i*(i+1)/2 + (j-i-1)
	function automatic int baseline_count(input int n);
		return n * (n - 1) / 2;
	endfunction

endpackage

// ==== rtl/tap_bus_if.sv ====
// delay line taps, fresh and changed flags and registered enable
`timescale 1ns/100ps

interface tap_bus_if #(
	parameter int NUM_INPUTS = 4,
	parameter int LAGS       = 3
);
	logic [LAGS:0]           taps [NUM_INPUTS]; // bit 0 is newest sample
	logic [NUM_INPUTS-1:0]   fresh;             // one cycle after a shift
	logic [NUM_INPUTS-1:0]   changed;           // tap 0 differs from tap 1
	logic                    enable_q;

	modport source (
		output taps, fresh, changed, enable_q
	);

	modport sink (
		input taps, fresh, changed, enable_q
	);

endinterface

// ==== rtl/sample_delay_bank.sv ====
// strobed per-input shift registers with fresh and changed flags
`timescale 1ns/100ps

module sample_delay_bank #(
	parameter int NUM_INPUTS = 4,
	parameter int LAGS       = 3
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [NUM_INPUTS-1:0] samples,
	input  logic [NUM_INPUTS-1:0] sample_strobe,
	input  logic                  enable,
	tap_bus_if.source             taps
);

	always_ff @(posedge clk) begin
		if (!reset) begin
			taps.fresh    <= '0;
			taps.changed  <= '0;
			taps.enable_q <= 1'b0;
			for (int n = 0; n < NUM_INPUTS; n++) begin
				taps.taps[n] <= '0;
			end
		end else begin
			taps.enable_q <= enable; // lines up with fresh for the array
			for (int n = 0; n < NUM_INPUTS; n++) begin
				taps.fresh[n]   <= sample_strobe[n];
				taps.changed[n] <= sample_strobe[n] & (samples[n] ^ taps.taps[n][0]);
				if (sample_strobe[n]) begin
					taps.taps[n] <= {taps.taps[n][LAGS-1:0], samples[n]};
				end
			end
		end
	end

endmodule

// ==== rtl/correlator_array.sv ====
// per-baseline and per-lag real and imaginary agreement counters
`timescale 1ns/100ps

module correlator_array #(
	parameter int NUM_INPUTS  = 4,
	parameter int LAGS        = 3,
	parameter int COUNT_WIDTH = 8
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    clear,
	input  corr_pkg::accum_mode_e   mode,
	tap_bus_if.sink                 taps,
	output logic [COUNT_WIDTH-1:0]  real_counts [corr_pkg::baseline_count(NUM_INPUTS)][LAGS],
	output logic [COUNT_WIDTH-1:0]  imag_counts [corr_pkg::baseline_count(NUM_INPUTS)][LAGS]
);
	import corr_pkg::*;

	localparam logic [COUNT_WIDTH-1:0] FULL_SCALE = '1;

	// a fresh sample on input n is counted for every baseline it leads
	logic [NUM_INPUTS-1:0] lead_hit;

	always_comb begin
		for (int n = 0; n < NUM_INPUTS; n++) begin
			lead_hit[n] = taps.fresh[n] && taps.enable_q &&
				(mode == mode_cumulative || taps.changed[n]);
		end
	end

	for (genvar i = 0; i < NUM_INPUTS - 1; i++) begin : g_lead
		for (genvar j = i + 1; j < NUM_INPUTS; j++) begin : g_partner
			localparam int B = i * NUM_INPUTS - i * (i + 1) / 2 + (j - i - 1);

			for (genvar k = 0; k < LAGS; k++) begin : g_lag
				logic                   agree_re;
				logic                   agree_im;
				logic                   frozen;
				logic [COUNT_WIDTH-1:0] re_q;
				logic [COUNT_WIDTH-1:0] im_q;

				assign agree_re = ~(taps.taps[i][0] ^ taps.taps[j][k]);
				assign agree_im = ~(taps.taps[i][0] ^ taps.taps[j][k+1]); // quarter step
				assign frozen   = (re_q == FULL_SCALE) || (im_q == FULL_SCALE);

				always_ff @(posedge clk) begin
					if (!reset || clear) begin
						re_q <= '0;
						im_q <= '0;
					end else if (lead_hit[i] && !frozen) begin
						// both counts stop together once either saturates
						re_q <= re_q + COUNT_WIDTH'(agree_re);
						im_q <= im_q + COUNT_WIDTH'(agree_im);
					end
				end

				assign real_counts[B][k] = re_q;
				assign imag_counts[B][k] = im_q;
			end
		end
	end

endmodule

// ==== rtl/count_readout.sv ====
// sequencer streaming real and imaginary counts one word per cycle
`timescale 1ns/100ps

module count_readout #(
	parameter int NUM_INPUTS  = 4,
	parameter int LAGS        = 3,
	parameter int COUNT_WIDTH = 8
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    read,
	input  logic [COUNT_WIDTH-1:0]  real_counts [corr_pkg::baseline_count(NUM_INPUTS)][LAGS],
	input  logic [COUNT_WIDTH-1:0]  imag_counts [corr_pkg::baseline_count(NUM_INPUTS)][LAGS],
	output logic [COUNT_WIDTH-1:0]  count_out,
	output logic                    count_valid,
	output logic                    count_last,
	output logic                    busy
);
	import corr_pkg::*;

	localparam int NUM_BASELINES = baseline_count(NUM_INPUTS);
	localparam int BW = (NUM_BASELINES > 1) ? $clog2(NUM_BASELINES) : 1;
	localparam int LW = (LAGS > 1) ? $clog2(LAGS) : 1;

	readout_state_e  state;
	logic [BW-1:0]   bl_idx;
	logic [LW-1:0]   lag_idx;
	logic            imag_sel; // second word of a real/imag pair
	logic            last_word;

	assign last_word = (bl_idx == BW'(NUM_BASELINES - 1)) &&
		(lag_idx == LW'(LAGS - 1)) && imag_sel;

	always_ff @(posedge clk) begin
		if (!reset) begin
			state    <= rd_idle;
			bl_idx   <= '0;
			lag_idx  <= '0;
			imag_sel <= 1'b0;
		end else begin
			case (state)
				rd_idle: if (read) begin // read while sending is ignored
					state    <= rd_send;
					bl_idx   <= '0;
					lag_idx  <= '0;
					imag_sel <= 1'b0;
				end
				rd_send: begin
					imag_sel <= ~imag_sel;
					if (last_word) begin
						state <= rd_idle;
					end else if (imag_sel) begin
						if (lag_idx == LW'(LAGS - 1)) begin
							lag_idx <= '0;
							bl_idx  <= bl_idx + 1'b1;
						end else begin
							lag_idx <= lag_idx + 1'b1;
						end
					end
				end
				default: state <= rd_idle;
			endcase
		end
	end

	// live values with no snapshot
	assign count_out   = imag_sel ? imag_counts[bl_idx][lag_idx] : real_counts[bl_idx][lag_idx];
	assign count_valid = (state == rd_send);
	assign count_last  = (state == rd_send) && last_word;
	assign busy        = (state == rd_send);

endmodule

// ==== rtl/correlator_top.sv ====
// one-bit correlator top level with delay bank, counter array and serial readout
`timescale 1ns/100ps

module correlator_top #(
	parameter int NUM_INPUTS  = 4,
	parameter int LAGS        = 3,
	parameter int COUNT_WIDTH = 8
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [NUM_INPUTS-1:0]  samples,
	input  logic [NUM_INPUTS-1:0]  sample_strobe,
	input  logic                   enable,
	input  logic                   clear,
	input  corr_pkg::accum_mode_e  mode,
	input  logic                   read,
	output logic [COUNT_WIDTH-1:0] count_out,
	output logic                   count_valid,
	output logic                   count_last,
	output logic                   busy
);
	import corr_pkg::*;

	localparam int NUM_BASELINES = baseline_count(NUM_INPUTS);

	logic [COUNT_WIDTH-1:0] real_counts [NUM_BASELINES][LAGS];
	logic [COUNT_WIDTH-1:0] imag_counts [NUM_BASELINES][LAGS];

	tap_bus_if #(
		.NUM_INPUTS (NUM_INPUTS),
		.LAGS       (LAGS)
	) tap_bus ();

	sample_delay_bank #(
		.NUM_INPUTS (NUM_INPUTS),
		.LAGS       (LAGS)
	) u_delay_bank (
		.clk           (clk),
		.reset         (reset),
		.samples       (samples),
		.sample_strobe (sample_strobe),
		.enable        (enable),
		.taps          (tap_bus.source)
	);

	correlator_array #(
		.NUM_INPUTS  (NUM_INPUTS),
		.LAGS        (LAGS),
		.COUNT_WIDTH (COUNT_WIDTH)
	) u_array (
		.clk         (clk),
		.reset       (reset),
		.clear       (clear),
		.mode        (mode),
		.taps        (tap_bus.sink),
		.real_counts (real_counts),
		.imag_counts (imag_counts)
	);

	count_readout #(
		.NUM_INPUTS  (NUM_INPUTS),
		.LAGS        (LAGS),
		.COUNT_WIDTH (COUNT_WIDTH)
	) u_readout (
		.clk         (clk),
		.reset       (reset),
		.read        (read),
		.real_counts (real_counts),
		.imag_counts (imag_counts),
		.count_out   (count_out),
		.count_valid (count_valid),
		.count_last  (count_last),
		.busy        (busy)
	);

endmodule

// ==== verif/correlator_tb.sv ====
// clock, reset, reference model, directed tests and final report
`timescale 1ns/100ps

module correlator_tb;
	import corr_pkg::*;

	localparam int NI     = 4;
	localparam int LG     = 3;
	localparam int CW     = 8;
	localparam int NB     = NI * (NI - 1) / 2;
	localparam int NWORDS = 2 * NB * LG;

	logic           clk;
	logic           reset;
	logic [NI-1:0]  samples;
	logic [NI-1:0]  sample_strobe;
	logic           enable;
	logic           clear;
	accum_mode_e    mode;
	logic           read;
	logic [CW-1:0]  count_out;
	logic           count_valid;
	logic           count_last;
	logic           busy;

	// reference model state
	accum_mode_e    mode_sel;
	logic [CW-1:0]  m_real [NB][LG];
	logic [CW-1:0]  m_imag [NB][LG];
	logic [LG:0]    m_taps [NI];
	logic [NI-1:0]  p_fresh;
	logic [NI-1:0]  p_changed;
	logic           p_en;

	logic [CW-1:0]  stream [$];     // last readout
	logic [CW-1:0]  saved [$];
	logic [15:0]    lfsr_state = 16'd62;
	int             value_errors = 0;
	int             other_errors = 0;

	correlator_top #(
		.NUM_INPUTS  (NI),
		.LAGS        (LG),
		.COUNT_WIDTH (CW)
	) uut (
		.clk           (clk),
		.reset         (reset),
		.samples       (samples),
		.sample_strobe (sample_strobe),
		.enable        (enable),
		.clear         (clear),
		.mode          (mode),
		.read          (read),
		.count_out     (count_out),
		.count_valid   (count_valid),
		.count_last    (count_last),
		.busy          (busy)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic lfsr_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out)
			lfsr_state = lfsr_state ^ 16'hB400;
		return out;
	endfunction

	function automatic logic [NI-1:0] lfsr_word();
		logic [NI-1:0] w;
		for (int n = 0; n < NI; n++)
			w[n] = lfsr_bit();
		return w;
	endfunction

	task automatic model_reset();
		for (int b = 0; b < NB; b++) begin
			for (int k = 0; k < LG; k++) begin
				m_real[b][k] = '0;
				m_imag[b][k] = '0;
			end
		end
		for (int n = 0; n < NI; n++)
			m_taps[n] = '0;
		p_fresh   = '0;
		p_changed = '0;
		p_en      = 1'b0;
	endtask

	// one clock edge that counts with the old taps and then shifts them
	task automatic model_edge(input logic [NI-1:0] smp, input logic [NI-1:0] stb,
			input logic en, input logic clr);
		int   b;
		logic hit;
		logic agree_re;
		logic agree_im;
		b = 0;
		for (int i = 0; i < NI - 1; i++) begin
			hit = p_fresh[i] && p_en && (mode_sel == mode_cumulative || p_changed[i]);
			for (int j = i + 1; j < NI; j++) begin
				for (int k = 0; k < LG; k++) begin
					agree_re = (m_taps[i][0] == m_taps[j][k]);
					agree_im = (m_taps[i][0] == m_taps[j][k+1]);
					if (clr) begin
						m_real[b][k] = '0;
						m_imag[b][k] = '0;
					end else if (hit && m_real[b][k] != '1 && m_imag[b][k] != '1) begin
						m_real[b][k] += {{(CW-1){1'b0}}, agree_re};
						m_imag[b][k] += {{(CW-1){1'b0}}, agree_im};
					end
				end
				b++;
			end
		end
		for (int n = 0; n < NI; n++) begin
			p_fresh[n]   = stb[n];
			p_changed[n] = stb[n] && (smp[n] != m_taps[n][0]);
			if (stb[n])
				m_taps[n] = {m_taps[n][LG-1:0], smp[n]};
		end
		p_en = en;
	endtask

	task automatic drive_cycle(input logic [NI-1:0] smp, input logic [NI-1:0] stb,
			input logic en, input logic clr, input logic rd);
		@(negedge clk);
		samples       = smp;
		sample_strobe = stb;
		enable        = en;
		clear         = clr;
		read          = rd;
		mode          = mode_sel;
		model_edge(smp, stb, en, clr);
	endtask

	// pulses read and checks every word against the model
	// extra_read is the word index of a read sent while busy
	task automatic read_and_check(input int extra_read);
		logic [CW-1:0] exp_q [$];
		int            waited;
		for (int b = 0; b < NB; b++) begin
			for (int k = 0; k < LG; k++) begin
				exp_q.push_back(m_real[b][k]);
				exp_q.push_back(m_imag[b][k]);
			end
		end
		stream.delete();
		assert (busy === 1'b0) else begin
			other_errors++;
			$display("busy is high at %0t while the readout should be idle", $time);
		end
		drive_cycle('0, '0, 1'b1, 1'b0, 1'b1);
		waited = 0;
		@(negedge clk);
		read = 1'b0;
		while (count_valid !== 1'b1 && waited < 16) begin
			@(negedge clk);
			waited++;
		end
		assert (count_valid === 1'b1) else begin
			other_errors++;
			$display("readout did not start within 16 cycles of the read pulse");
		end
		if (count_valid !== 1'b1)
			return;
		for (int w = 0; w < NWORDS; w++) begin
			read = (w == extra_read);
			assert (count_valid === 1'b1 && busy === 1'b1) else begin
				other_errors++;
				$display("stream broke off at word %0d, time %0t", w + 1, $time);
			end
			assert (count_out === exp_q[w]) else begin
				value_errors++;
				$display("Mismatch at %0t: count_out word %0d = %0d, expected %0d",
					$time, w + 1, count_out, exp_q[w]);
			end
			assert (count_last === (w == NWORDS - 1)) else begin
				value_errors++;
				$display("Mismatch at %0t: count_last on word %0d = %b, expected %b",
					$time, w + 1, count_last, (w == NWORDS - 1));
			end
			stream.push_back(count_out);
			@(negedge clk);
		end
		read = 1'b0;
		assert (busy === 1'b0 && count_valid === 1'b0) else begin
			other_errors++;
			$display("readout still active after the last word at %0t", $time);
		end
	endtask

	task automatic test_reset_zero();
		mode_sel = mode_cumulative;
		read_and_check(-1);
		foreach (stream[w]) begin
			assert (stream[w] === '0) else begin
				value_errors++;
				$display("Mismatch at %0t: count_out word %0d = %0d, expected 0",
					$time, w + 1, stream[w]);
			end
		end
		drive_cycle(4'b1010, 4'b1111, 1'b1, 1'b0, 1'b0);
		drive_cycle(4'b0110, 4'b1111, 1'b1, 1'b0, 1'b0);
		drive_cycle('0, '0, 1'b1, 1'b1, 1'b0); // clear
		drive_cycle('0, '0, 1'b1, 1'b0, 1'b0);
		read_and_check(-1);
		foreach (stream[w]) begin
			assert (stream[w] === '0) else begin
				value_errors++;
				$display("Mismatch at %0t: count_out word %0d after clear = %0d, expected 0",
					$time, w + 1, stream[w]);
			end
		end
	endtask

	task automatic test_cumulative();
		logic [NI-1:0] pat_s [10] = '{4'h5, 4'hA, 4'hF, 4'h3, 4'h0, 4'hC, 4'h9, 4'h6, 4'h1, 4'hE};
		logic [NI-1:0] pat_t [10] = '{4'hF, 4'hF, 4'h1, 4'h3, 4'h8, 4'hF, 4'h6, 4'h1, 4'hB, 4'hF};
		mode_sel = mode_cumulative;
		drive_cycle('0, '0, 1'b1, 1'b1, 1'b0);
		for (int s = 0; s < 10; s++)
			drive_cycle(pat_s[s], pat_t[s], 1'b1, 1'b0, 1'b0);
		drive_cycle('0, '0, 1'b1, 1'b0, 1'b0);
		read_and_check(-1);
	endtask

	task automatic test_transition();
		int sum;
		mode_sel = mode_transition;
		drive_cycle(4'b0000, 4'b0010, 1'b1, 1'b0, 1'b0); // settle tap 0 of input 1
		drive_cycle('0, '0, 1'b1, 1'b1, 1'b0);
		for (int s = 0; s < 6; s++)
			drive_cycle(4'b0000, 4'b0010, 1'b1, 1'b0, 1'b0);
		drive_cycle('0, '0, 1'b1, 1'b0, 1'b0);
		read_and_check(-1);
		foreach (stream[w]) begin
			assert (stream[w] === '0) else begin
				value_errors++;
				$display({"Mismatch at %0t: count_out word %0d after repeated samples",
					" = %0d, expected 0"}, $time, w + 1, stream[w]);
			end
		end
		for (int s = 0; s < 6; s++)
			drive_cycle({2'b00, s[0], 1'b0}, 4'b0011, 1'b1, 1'b0, 1'b0);
		drive_cycle('0, '0, 1'b1, 1'b0, 1'b0);
		read_and_check(-1);
		sum = 0;
		for (int w = 18; w < 30; w++)  // baselines (1,2) and (1,3)
			sum += stream[w];
		assert (sum > 0) else begin
			other_errors++;
			$display("alternating samples on input 1 added nothing in transition mode");
		end
	endtask

	task automatic test_enable_gate();
		mode_sel = mode_cumulative;
		read_and_check(-1);
		saved = stream;
		for (int s = 0; s < 8; s++)
			drive_cycle(lfsr_word(), lfsr_word(), 1'b0, 1'b0, 1'b0);
		drive_cycle('0, '0, 1'b0, 1'b0, 1'b0);
		read_and_check(-1);
		foreach (stream[w]) begin
			assert (stream[w] === saved[w]) else begin
				value_errors++;
				$display("Mismatch at %0t: count_out word %0d = %0d, before gated strobes %0d",
					$time, w + 1, stream[w], saved[w]);
			end
		end
	endtask

	task automatic test_saturation();
		mode_sel = mode_cumulative;
		for (int s = 0; s <= LG; s++)
			drive_cycle(4'hF, 4'hF, 1'b1, 1'b0, 1'b0);
		drive_cycle('0, '0, 1'b1, 1'b1, 1'b0);
		for (int s = 0; s < 300; s++)
			drive_cycle(4'hF, 4'b0001, 1'b1, 1'b0, 1'b0);
		drive_cycle('0, '0, 1'b1, 1'b0, 1'b0);
		read_and_check(-1);
		for (int w = 0; w < 2 * 3 * LG; w++) begin  // baselines led by input 0
			assert (stream[w] === '1) else begin
				value_errors++;
				$display("Mismatch at %0t: count_out word %0d = %0d, expected %0d",
					$time, w + 1, stream[w], 8'hFF);
			end
		end
	endtask

	task automatic test_random();
		mode_sel = mode_cumulative;
		drive_cycle('0, '0, 1'b1, 1'b1, 1'b0);
		for (int s = 0; s < 200; s++)
			drive_cycle(lfsr_word(), lfsr_word(), 1'b1, 1'b0, 1'b0);
		drive_cycle('0, '0, 1'b1, 1'b0, 1'b0);
		read_and_check(5); // second read lands mid-stream
	endtask

	initial begin
		reset         = 1'b0;
		samples       = '0;
		sample_strobe = '0;
		enable        = 1'b0;
		clear         = 1'b0;
		read          = 1'b0;
		mode_sel      = mode_cumulative;
		mode          = mode_cumulative;
		model_reset();
		for (int c = 0; c < 16; c++)
			@(negedge clk);
		reset = 1'b1;

		test_reset_zero();
		test_cumulative();
		test_transition();
		test_enable_gate();
		test_saturation();
		test_random();

		$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
rtl/corr_pkg.sv
rtl/tap_bus_if.sv
rtl/sample_delay_bank.sv
rtl/correlator_array.sv
rtl/count_readout.sv
rtl/correlator_top.sv
verif/correlator_tb.sv

// ==== Bender.yml ====
package:
  name: correlator

sources:
  - rtl/corr_pkg.sv
  - rtl/tap_bus_if.sv
  - rtl/sample_delay_bank.sv
  - rtl/correlator_array.sv
  - rtl/count_readout.sv
  - rtl/correlator_top.sv
  - target: test
    files:
      - verif/correlator_tb.sv
